/* rtl/core_pkg.sv */
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 2 ** REG_ADDR_W;
    localparam int ISSUE_WIDTH = 2;
    localparam int RF_RD_PORTS = 2 * ISSUE_WIDTH;
    localparam int IB_DEPTH    = 8;
    localparam int IB_PTR_W    = 3;

    // 3R major opcodes, instr[31:15]
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;

    // 2RI12 opcodes, instr[31:22]
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_ANDI   = 10'h00d;
    localparam logic [9:0]  OPC_ORI    = 10'h00e;

    // 2RI16 opcodes, instr[31:26]
    localparam logic [5:0]  OPC_BEQ    = 6'h16;
    localparam logic [5:0]  OPC_BNE    = 6'h17;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [11:0]           si12;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [15:0]           offs16;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } fmt_2ri16_t;

    // rj and rd sit at the same bits in every format
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_2ri16_t ri16;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BEQ,
        ALU_BNE,
        ALU_NOP
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } fetch_slot_t;

    // Slot 0 is the older instruction
    typedef fetch_slot_t [ISSUE_WIDTH-1:0] fetch_bundle_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rj;
        // Second source, rd for branches
        logic [REG_ADDR_W-1:0] rk;
        logic                  uses_imm;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  writes_rd;
        logic                  is_branch;
    } uop_t;

    typedef struct packed {
        uop_t            uop;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  rf_wen;
        logic [REG_ADDR_W-1:0] wnum;
        logic [XLEN-1:0]       wdata;
    } commit_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] wnum;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

endpackage

/* rtl/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  core_pkg::fetch_bundle_t push_i,
    input  logic [1:0]              pop_count_i,
    output core_pkg::fetch_bundle_t head_o,
    output logic                    full_o
);

    import core_pkg::*;

    fetch_slot_t         mem_q [IB_DEPTH];
    logic [IB_PTR_W-1:0] head_q;
    logic [IB_PTR_W-1:0] tail_q;
    logic [IB_PTR_W-1:0] tail_next;
    logic [IB_PTR_W:0]   count_q;
    logic                push_en;
    logic [1:0]          push_n;

    // Stall fetch while fewer than two entries are free
    assign full_o = count_q > (IB_DEPTH - 2);

    // A flush drops the bundle offered on the same edge
    assign push_en   = !full_o && !flush_i;
    assign push_n    = push_en ? ({1'b0, push_i[0].valid} + {1'b0, push_i[1].valid}) : 2'd0;
    assign tail_next = tail_q + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + IB_PTR_W'(pop_count_i);
            tail_q  <= tail_q + IB_PTR_W'(push_n);
            count_q <= count_q + (IB_PTR_W + 1)'(push_n) - (IB_PTR_W + 1)'(pop_count_i);
        end
    end

    always_ff @(posedge clk) begin
        if (push_en && push_i[0].valid) begin
            mem_q[tail_q] <= push_i[0];
        end
        if (push_en && push_i[1].valid) begin
            mem_q[tail_next] <= push_i[1];
        end
    end

    // Two oldest entries, invalid beyond the fill level
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            head_o[i]       = mem_q[head_q + IB_PTR_W'(i)];
            head_o[i].valid = count_q > i;
        end
    end

    // Dispatch never takes more than the buffer holds
    a_pop_le_count: assert property (
        @(posedge clk) disable iff (reset_i)
        pop_count_i <= count_q
    );

    // Held fetch bundles must not overfill the buffer
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset_i)
        count_q <= IB_DEPTH
    );

endmodule

/* rtl/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  core_pkg::fetch_slot_t slot_i,
    output core_pkg::uop_t        uop_o
);

    import core_pkg::*;

    instr_u          word;
    logic [XLEN-1:0] si12_sext;
    logic [XLEN-1:0] ui12_zext;
    logic [XLEN-1:0] offs_sext;

    assign word      = slot_i.instr;
    assign si12_sext = {{(XLEN - 12){word.ri12.si12[11]}}, word.ri12.si12};
    assign ui12_zext = {{(XLEN - 12){1'b0}}, word.ri12.si12};
    // Word offset becomes a byte offset
    assign offs_sext = {{(XLEN - 18){word.ri16.offs16[15]}}, word.ri16.offs16, 2'b00};

    always_comb begin
        uop_o        = '0;
        uop_o.valid  = slot_i.valid;
        uop_o.pc     = slot_i.pc;
        uop_o.alu_op = ALU_NOP;
        uop_o.rj     = word.r3.rj;
        uop_o.rk     = word.r3.rk;
        uop_o.rd     = word.r3.rd;

        // Opcode spaces of the three formats do not overlap
        case (word.r3.opcode)
            OPC_ADD_W: uop_o.alu_op = ALU_ADD;
            OPC_SUB_W: uop_o.alu_op = ALU_SUB;
            OPC_AND:   uop_o.alu_op = ALU_AND;
            OPC_OR:    uop_o.alu_op = ALU_OR;
            OPC_XOR:   uop_o.alu_op = ALU_XOR;
            default:   ;
        endcase

        case (word.ri12.opcode)
            OPC_ADDI_W: begin
                uop_o.alu_op   = ALU_ADD;
                uop_o.uses_imm = 1'b1;
                uop_o.imm      = si12_sext;
            end
            OPC_ANDI: begin
                uop_o.alu_op   = ALU_AND;
                uop_o.uses_imm = 1'b1;
                uop_o.imm      = ui12_zext;
            end
            OPC_ORI: begin
                uop_o.alu_op   = ALU_OR;
                uop_o.uses_imm = 1'b1;
                uop_o.imm      = ui12_zext;
            end
            default: ;
        endcase

        // Branches compare rj with rd
        if (word.ri16.opcode == OPC_BEQ || word.ri16.opcode == OPC_BNE) begin
            uop_o.alu_op    = (word.ri16.opcode == OPC_BEQ) ? ALU_BEQ : ALU_BNE;
            uop_o.rk        = word.ri16.rd;
            uop_o.imm       = offs_sext;
            uop_o.is_branch = 1'b1;
        end

        uop_o.writes_rd = (uop_o.alu_op != ALU_NOP) && !uop_o.is_branch &&
                          (word.r3.rd != '0);
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                                                       clk,
    input  logic                                                       reset_i,
    input  logic [core_pkg::RF_RD_PORTS-1:0][core_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [core_pkg::RF_RD_PORTS-1:0][core_pkg::XLEN-1:0]       rdata_o,
    input  core_pkg::commit_t [core_pkg::ISSUE_WIDTH-1:0]              wr_i
);

    import core_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // Lane 1 is younger so its write lands last
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wr_i[i].valid && wr_i[i].rf_wen && wr_i[i].wnum != '0) begin
                    regs_q[wr_i[i].wnum] <= wr_i[i].wdata;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < RF_RD_PORTS; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs_q[raddr_i[p]];
        end
    end

endmodule

/* rtl/dispatch.sv */
`timescale 1ns/1ps

module dispatch (
    input  logic                                                       clk,
    input  logic                                                       reset_i,
    input  logic                                                       flush_i,
    input  core_pkg::uop_t [core_pkg::ISSUE_WIDTH-1:0]                 uop_i,
    output logic [core_pkg::RF_RD_PORTS-1:0][core_pkg::REG_ADDR_W-1:0] raddr_o,
    input  logic [core_pkg::RF_RD_PORTS-1:0][core_pkg::XLEN-1:0]       rdata_i,
    input  core_pkg::fwd_t [core_pkg::ISSUE_WIDTH-1:0]                 fwd_ex_i,
    input  core_pkg::fwd_t [core_pkg::ISSUE_WIDTH-1:0]                 fwd_wb_i,
    output logic [1:0]                                                 pop_count_o,
    output core_pkg::issue_t [core_pkg::ISSUE_WIDTH-1:0]               issue_o
);

    import core_pkg::*;

    logic                      hazard;
    logic                      pair_ok;
    logic [ISSUE_WIDTH-1:0]    issue_en;
    issue_t [ISSUE_WIDTH-1:0]  issue_d;
    issue_t [ISSUE_WIDTH-1:0]  issue_q;

    // Later matches win: commit lanes first, then execute lanes, younger last
    function automatic logic [XLEN-1:0] operand(
        input logic [REG_ADDR_W-1:0]  r,
        input logic [XLEN-1:0]        rf_val,
        input fwd_t [ISSUE_WIDTH-1:0] ex,
        input fwd_t [ISSUE_WIDTH-1:0] wb
    );
        logic [XLEN-1:0] v;
        v = rf_val;
        if (r != '0) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (wb[i].valid && wb[i].wnum == r) begin
                    v = wb[i].wdata;
                end
            end
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (ex[i].valid && ex[i].wnum == r) begin
                    v = ex[i].wdata;
                end
            end
        end
        return v;
    endfunction

    // Slot 1 reading slot 0's result must wait a cycle
    assign hazard = uop_i[0].writes_rd &&
                    ((uop_i[1].rj == uop_i[0].rd) ||
                     (!uop_i[1].uses_imm && uop_i[1].rk == uop_i[0].rd));

    assign pair_ok = !hazard && !uop_i[0].is_branch && !uop_i[1].is_branch;

    assign issue_en[0] = uop_i[0].valid;
    assign issue_en[1] = uop_i[0].valid && uop_i[1].valid && pair_ok;
    assign pop_count_o = {1'b0, issue_en[0]} + {1'b0, issue_en[1]};

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            raddr_o[2*i]         = uop_i[i].rj;
            raddr_o[2*i+1]       = uop_i[i].rk;
            issue_d[i].uop       = uop_i[i];
            issue_d[i].uop.valid = issue_en[i];
            issue_d[i].src1      = operand(uop_i[i].rj, rdata_i[2*i], fwd_ex_i, fwd_wb_i);
            issue_d[i].src2      = operand(uop_i[i].rk, rdata_i[2*i+1], fwd_ex_i, fwd_wb_i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            issue_q <= '0;
        end else begin
            issue_q <= issue_d;
        end
    end

    assign issue_o = issue_q;

    // Buffer offers its entries oldest first
    a_lane1_with_lane0: assert property (
        @(posedge clk) disable iff (reset_i)
        uop_i[1].valid |-> uop_i[0].valid
    );

endmodule

/* rtl/execute_lane.sv */
`timescale 1ns/1ps

module execute_lane (
    input  logic                        clk,
    input  logic                        reset_i,
    input  core_pkg::issue_t            issue_i,
    output core_pkg::fwd_t              fwd_o,
    output logic                        taken_o,
    output logic [core_pkg::XLEN-1:0]   target_o,
    output core_pkg::commit_t           commit_o
);

    import core_pkg::*;

    uop_t                  uop;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       result;
    logic                  equal;
    logic                  wen;

    logic                  valid_q;
    logic                  wen_q;
    logic [XLEN-1:0]       pc_q;
    logic [REG_ADDR_W-1:0] wnum_q;
    logic [XLEN-1:0]       wdata_q;

    assign uop   = issue_i.uop;
    assign op_b  = uop.uses_imm ? uop.imm : issue_i.src2;
    assign equal = issue_i.src1 == issue_i.src2;

    always_comb begin
        case (uop.alu_op)
            ALU_ADD: result = issue_i.src1 + op_b;
            ALU_SUB: result = issue_i.src1 - op_b;
            ALU_AND: result = issue_i.src1 & op_b;
            ALU_OR:  result = issue_i.src1 | op_b;
            ALU_XOR: result = issue_i.src1 ^ op_b;
            default: result = '0;
        endcase
    end

    assign wen = uop.valid && uop.writes_rd;

    // Branch resolution
    assign taken_o  = uop.valid && uop.is_branch &&
                      ((uop.alu_op == ALU_BEQ) ? equal : !equal);
    assign target_o = uop.pc + uop.imm;

    // Result seen by dispatch in the same cycle
    assign fwd_o.valid = wen;
    assign fwd_o.wnum  = uop.rd;
    assign fwd_o.wdata = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            valid_q <= uop.valid;
            wen_q   <= wen;
        end
    end

    // No-write commits show zero number and data
    always_ff @(posedge clk) begin
        pc_q    <= uop.pc;
        wnum_q  <= wen ? uop.rd : '0;
        wdata_q <= wen ? result : '0;
    end

    assign commit_o.valid  = valid_q;
    assign commit_o.pc     = pc_q;
    assign commit_o.rf_wen = wen_q;
    assign commit_o.wnum   = wnum_q;
    assign commit_o.wdata  = wdata_q;

    // A taken branch commits next cycle without a write
    a_taken_commits: assert property (
        @(posedge clk) disable iff (reset_i)
        taken_o |=> commit_o.valid && !commit_o.rf_wen
    );

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  core_pkg::fetch_bundle_t                       fetch_i,
    output logic                                          fetch_stall_o,
    output core_pkg::commit_t [core_pkg::ISSUE_WIDTH-1:0] commit_o,
    output logic                                          redirect_o,
    output logic [core_pkg::XLEN-1:0]                     redirect_pc_o
);

    import core_pkg::*;

    logic                                   flush;
    fetch_bundle_t                          ib_head;
    logic [1:0]                             pop_count;
    uop_t [ISSUE_WIDTH-1:0]                 uop;
    logic [RF_RD_PORTS-1:0][REG_ADDR_W-1:0] rf_raddr;
    logic [RF_RD_PORTS-1:0][XLEN-1:0]       rf_rdata;
    fwd_t [ISSUE_WIDTH-1:0]                 fwd_ex;
    fwd_t [ISSUE_WIDTH-1:0]                 fwd_wb;
    issue_t [ISSUE_WIDTH-1:0]               issue;
    logic [ISSUE_WIDTH-1:0]                 lane_taken;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       lane_target;

    // Branches only issue in lane 0, so it alone redirects
    assign flush = lane_taken[0];

    instr_buffer u_instr_buffer (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .push_i     (fetch_i),
        .pop_count_i(pop_count),
        .head_o     (ib_head),
        .full_o     (fetch_stall_o)
    );

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        decoder u_decoder (
            .slot_i(ib_head[i]),
            .uop_o (uop[i])
        );

        execute_lane u_execute_lane (
            .clk     (clk),
            .reset_i (reset_i),
            .issue_i (issue[i]),
            .fwd_o   (fwd_ex[i]),
            .taken_o (lane_taken[i]),
            .target_o(lane_target[i]),
            .commit_o(commit_o[i])
        );

        // Commit stage forwarding covers the write still in flight
        assign fwd_wb[i].valid = commit_o[i].valid && commit_o[i].rf_wen;
        assign fwd_wb[i].wnum  = commit_o[i].wnum;
        assign fwd_wb[i].wdata = commit_o[i].wdata;
    end

    dispatch u_dispatch (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .uop_i      (uop),
        .raddr_o    (rf_raddr),
        .rdata_i    (rf_rdata),
        .fwd_ex_i   (fwd_ex),
        .fwd_wb_i   (fwd_wb),
        .pop_count_o(pop_count),
        .issue_o    (issue)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset_i(reset_i),
        .raddr_i(rf_raddr),
        .rdata_o(rf_rdata),
        .wr_i   (commit_o)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o <= 1'b0;
        end else begin
            redirect_o <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            redirect_pc_o <= lane_target[0];
        end
    end

    a_lane1_never_taken: assert property (
        @(posedge clk) disable iff (reset_i)
        !lane_taken[1]
    );

    // Younger work is gone when the redirect shows
    a_flush_clears_issue: assert property (
        @(posedge clk) disable iff (reset_i)
        flush |=> !ib_head[0].valid && !issue[0].uop.valid && !issue[1].uop.valid
    );

endmodule

/* dv/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Instruction kinds, ALU kinds first so that a range test finds the writers
typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_ANDI, K_ORI, K_BEQ, K_BNE, K_BAD
} kind_e;

typedef struct packed {
    kind_e       kind;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [15:0] imm;
} prog_rec_t;

typedef struct packed {
    logic [31:0] pc;
    logic        wen;
    logic [4:0]  wnum;
    logic [31:0] wdata;
} exp_commit_t;

logic [31:0] lcg_state = 32'hdb734cff;
logic [31:0] model_regs [32];
prog_rec_t   prog [$];
logic [31:0] prog_base;
exp_commit_t exp_q [$];
logic [31:0] redirect_q [$];

function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Low bits of an LCG are weak
    return int'(lcg_state[30:8]) % n;
endfunction

function automatic logic [31:0] encode(input prog_rec_t r);
    case (r.kind)
        K_ADD:   return {OPC_ADD_W, r.rk, r.rj, r.rd};
        K_SUB:   return {OPC_SUB_W, r.rk, r.rj, r.rd};
        K_AND:   return {OPC_AND, r.rk, r.rj, r.rd};
        K_OR:    return {OPC_OR, r.rk, r.rj, r.rd};
        K_XOR:   return {OPC_XOR, r.rk, r.rj, r.rd};
        K_ADDI:  return {OPC_ADDI_W, r.imm[11:0], r.rj, r.rd};
        K_ANDI:  return {OPC_ANDI, r.imm[11:0], r.rj, r.rd};
        K_ORI:   return {OPC_ORI, r.imm[11:0], r.rj, r.rd};
        K_BEQ:   return {OPC_BEQ, r.imm, r.rj, r.rd};
        K_BNE:   return {OPC_BNE, r.imm, r.rj, r.rd};
        default: return 32'h0;
    endcase
endfunction

// Walks the program in order and queues the commits and redirects
task automatic run_model();
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        taken;
    logic        wen;
    int          idx;
    prog_rec_t   r;
    pc  = prog_base;
    idx = 0;
    while (idx < prog.size()) begin
        r     = prog[idx];
        a     = model_regs[r.rj];
        b     = (r.kind == K_BEQ || r.kind == K_BNE) ? model_regs[r.rd] : model_regs[r.rk];
        val   = 32'h0;
        taken = 1'b0;
        case (r.kind)
            K_ADD:   val = a + b;
            K_SUB:   val = a - b;
            K_AND:   val = a & b;
            K_OR:    val = a | b;
            K_XOR:   val = a ^ b;
            K_ADDI:  val = a + {{20{r.imm[11]}}, r.imm[11:0]};
            K_ANDI:  val = a & {20'h0, r.imm[11:0]};
            K_ORI:   val = a | {20'h0, r.imm[11:0]};
            K_BEQ:   taken = (a == b);
            K_BNE:   taken = (a != b);
            default: ;
        endcase
        // r0 stays zero
        wen = (r.kind <= K_ORI) && (r.rd != 5'd0);
        if (wen) begin
            model_regs[r.rd] = val;
        end
        exp_q.push_back({pc, wen, r.rd, val});
        if (taken) begin
            pc = pc + {{14{r.imm[15]}}, r.imm, 2'b00};
            redirect_q.push_back(pc);
            idx = int'((pc - prog_base) >> 2);
        end else begin
            pc  = pc + 32'd4;
            idx = idx + 1;
        end
    end
endtask

`endif

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    import core_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int TOTAL_INSTR = 40 + 48 + 60 + 64;

    logic                      clk;
    logic                      reset_i;
    fetch_bundle_t             fetch_i;
    logic                      fetch_stall_o;
    commit_t [ISSUE_WIDTH-1:0] commit_o;
    logic                      redirect_o;
    logic [XLEN-1:0]           redirect_pc_o;

    logic        running;
    logic        quiet;
    logic        offered;
    logic        offered_stall;
    logic        stall_seen;
    logic [31:0] fetch_pc;
    int          error_count;
    int          commit_count;
    int          redirect_count;

    `include "core_model.svh"

    core_top u_core_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_i      (fetch_i),
        .fetch_stall_o(fetch_stall_o),
        .commit_o     (commit_o),
        .redirect_o   (redirect_o),
        .redirect_pc_o(redirect_pc_o)
    );

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        error_count++;
        $display("error %s: expected 0x%h, actual 0x%h", name, exp, act);
    endtask

    task automatic check_commit(input int l);
        exp_commit_t e;
        if (exp_q.size() == 0) begin
            error_count++;
            $display("lane %0d committed pc %h with nothing left to commit", l, commit_o[l].pc);
        end else begin
            e = exp_q.pop_front();
            commit_count++;
            assert (commit_o[l].pc == e.pc)
                else report_mismatch($sformatf("commit_o[%0d].pc", l), e.pc, commit_o[l].pc);
            assert (commit_o[l].rf_wen == e.wen)
                else report_mismatch($sformatf("commit_o[%0d].rf_wen", l), 32'(e.wen),
                                     32'(commit_o[l].rf_wen));
            if (e.wen) begin
                assert (commit_o[l].wnum == e.wnum)
                    else report_mismatch($sformatf("commit_o[%0d].wnum", l), 32'(e.wnum),
                                         32'(commit_o[l].wnum));
                assert (commit_o[l].wdata == e.wdata)
                    else report_mismatch($sformatf("commit_o[%0d].wdata", l), e.wdata,
                                         commit_o[l].wdata);
            end
        end
    endtask

    function automatic fetch_slot_t make_slot(input logic [31:0] pc);
        fetch_slot_t s;
        int          idx;
        s   = '0;
        idx = int'((pc - prog_base) >> 2);
        if (idx < prog.size()) begin
            s.valid = 1'b1;
            s.pc    = pc;
            s.instr = encode(prog[idx]);
        end
        return s;
    endfunction

    task automatic build_program(input int n, input int pool, input int branch_pct,
                                 input int bad_pct, input bit chain);
        prog_rec_t r;
        prog.delete();
        for (int i = 0; i < n; i++) begin
            r.imm  = 16'(rand_below(1 << 16));
            r.rj   = 5'(rand_below(pool));
            r.rk   = 5'(rand_below(pool));
            r.rd   = (rand_below(8) == 0) ? 5'd0 : 5'(1 + rand_below(pool - 1));
            r.kind = kind_e'(rand_below(8));
            if (rand_below(100) < branch_pct) begin
                r.kind = rand_below(2) ? K_BNE : K_BEQ;
                // Same register on both sides makes BEQ taken
                if (rand_below(2) == 0) begin
                    r.rd = r.rj;
                end
                r.imm = 16'(1 + rand_below(5));
            end else if (rand_below(100) < bad_pct) begin
                r.kind = K_BAD;
            end
            if (chain) begin
                r.rd = 5'd5;
                r.rj = 5'd5;
            end
            prog.push_back(r);
        end
    endtask

    // Commit checks, then redirect handling and the next fetch bundle
    always @(negedge clk) begin : drive_and_check
        logic [31:0] target;
        logic        redirected;
        target     = redirect_pc_o;
        redirected = redirect_o;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (commit_o[l].valid) begin
                check_commit(l);
            end
        end
        if (redirect_o) begin
            redirect_count++;
            if (redirect_q.size() == 0) begin
                error_count++;
                $display("redirect to %h without a taken branch", redirect_pc_o);
            end else begin
                target = redirect_q.pop_front();
                assert (redirect_pc_o == target)
                    else report_mismatch("redirect_pc_o", target, redirect_pc_o);
            end
        end
        if (running) begin
            if (redirected) begin
                fetch_pc = target;
            end else if (offered && !offered_stall) begin
                fetch_pc = fetch_pc + 32'd8;
            end
            fetch_i[0]    = make_slot(fetch_pc);
            fetch_i[1]    = make_slot(fetch_pc + 32'd4);
            offered       = 1'b1;
            offered_stall = fetch_stall_o;
            if (fetch_stall_o) begin
                stall_seen = 1'b1;
            end
        end else begin
            fetch_i = '0;
            offered = 1'b0;
        end
    end

    task automatic run_program(input int num, input string name, input int n, input int pool,
                               input int branch_pct, input int bad_pct, input bit chain);
        int errors_before;
        int commits_before;
        @(posedge clk);
        errors_before  = error_count;
        commits_before = commit_count;
        prog_base      = 32'h1c00_0000 + 32'(num) * 32'h1000;
        build_program(n, pool, branch_pct, bad_pct, chain);
        run_model();
        fetch_pc       = prog_base;
        stall_seen     = 1'b0;
        redirect_count = 0;
        running        = 1'b1;
        while (exp_q.size() != 0 || redirect_q.size() != 0) begin
            @(posedge clk);
        end
        running = 1'b0;
        // Drain window catches stray commits
        repeat (6) @(posedge clk);
        if (num == 4 && redirect_count == 0) begin
            error_count++;
            $display("branch program produced no redirect");
        end
        if (num == 5 && !stall_seen) begin
            error_count++;
            $display("fetch stall never rose during the dependent stream");
        end
        $display("test %0d %s: %0d commits, %0d redirects, %0d errors", num, name,
                 commit_count - commits_before, redirect_count, error_count - errors_before);
    endtask

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (reset_i)
        quiet |-> !commit_o[0].valid && !commit_o[1].valid && !redirect_o && !fetch_stall_o
    ) else begin
        error_count++;
        $display("outputs became active after reset before any fetch");
    end

    a_redirect_pulse: assert property (
        @(posedge clk) disable iff (reset_i)
        redirect_o |=> !redirect_o
    ) else begin
        error_count++;
        $display("redirect stayed high for more than one cycle");
    end

    a_lane_order: assert property (
        @(posedge clk) disable iff (reset_i)
        commit_o[1].valid |-> commit_o[0].valid
    ) else begin
        error_count++;
        $display("lane 1 committed without lane 0");
    end

    initial begin
        clk            = 1'b0;
        reset_i        = 1'b1;
        fetch_i        = '0;
        running        = 1'b0;
        quiet          = 1'b0;
        offered        = 1'b0;
        offered_stall  = 1'b0;
        stall_seen     = 1'b0;
        fetch_pc       = 32'h0;
        prog_base      = 32'h0;
        error_count    = 0;
        commit_count   = 0;
        redirect_count = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = 32'h0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        quiet   = 1'b1;
        repeat (6) @(posedge clk);
        quiet = 1'b0;
        $display("test 1 reset_quiet: %0d errors", error_count);
        run_program(2, "alu_random", 40, 32, 0, 10, 1'b0);
        run_program(3, "dependent", 48, 4, 0, 0, 1'b0);
        run_program(4, "branches", 60, 6, 25, 0, 1'b0);
        run_program(5, "stall", 64, 8, 0, 0, 1'b1);
        $display("tests 5, commits checked %0d, errors %0d", commit_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Twenty cycles per instruction plus reset and drain slack
    initial begin : watchdog
        #(CLK_PERIOD * (TOTAL_INSTR * 20 + 40));
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_INSTR * 20 + 40);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
rtl/core_pkg.sv
rtl/instr_buffer.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/dispatch.sv
rtl/execute_lane.sv
rtl/core_top.sv
dv/core_tb.sv
